/* bench/dram_model.sv */
/*
 * DRAM models for the instruction and data buses, each ready
 * and valid delayed by a random 0 to 3 cycles
 */
`timescale 1ns/1ps
`default_nettype none

// one DRAM bank, answers bursts of BURST_LEN words in address order
module dram_bank import cpu_pkg::*; #(
	parameter int BURST_LEN = 1
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  ar_valid,
	output logic  ar_ready,
	input  addr_t ar_addr,
	output logic  r_valid,
	output word_t r_data,
	output logic  r_last,
	input  logic  r_ready,
	input  logic  aw_valid,
	output logic  aw_ready,
	input  addr_t aw_addr,
	input  word_t aw_data,
	output logic  b_valid,
	input  logic  b_ready
);

	typedef enum logic [2:0] {IDLE, ADDR, ACCEPT, GAP, BUSY} phase_e;

	word_t  mem [32768];
	phase_e rd_phase = IDLE;
	phase_e wr_phase = IDLE;
	int     rd_wait = 0;
	int     rd_left = 0;
	int     wr_wait = 0;
	addr_t  rd_addr = '0;
	logic   ar_ready_q = 1'b0;
	logic   r_valid_q = 1'b0;
	logic   r_last_q = 1'b0;
	word_t  r_data_q = '0;
	logic   aw_ready_q = 1'b0;
	logic   b_valid_q = 1'b0;

	assign ar_ready = ar_ready_q;
	assign r_valid = r_valid_q;
	assign r_last = r_last_q;
	assign r_data = r_data_q;
	assign aw_ready = aw_ready_q;
	assign b_valid = b_valid_q;

	// ##################################################
	// read channel
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_phase   <= IDLE;
			ar_ready_q <= 1'b0;
			r_valid_q  <= 1'b0;
			r_last_q   <= 1'b0;
			r_data_q   <= '0;
			rd_wait    <= 0;
			rd_left    <= 0;
			rd_addr    <= '0;
		end else begin
			case (rd_phase)
				IDLE: begin
					if (ar_valid) begin
						rd_wait  <= int'($urandom % 4);
						rd_phase <= ADDR;
					end
				end
				ADDR: begin
					if (rd_wait == 0) begin
						ar_ready_q <= 1'b1;
						rd_phase   <= ACCEPT;
					end else begin
						rd_wait <= rd_wait - 1;
					end
				end
				// address transfer happens at the end of this cycle
				ACCEPT: begin
					ar_ready_q <= 1'b0;
					rd_addr    <= ar_addr;
					rd_left    <= BURST_LEN;
					rd_wait    <= int'($urandom % 4);
					rd_phase   <= GAP;
				end
				GAP: begin
					if (rd_wait == 0) begin
						r_valid_q <= 1'b1;
						r_data_q  <= mem[rd_addr[15:1]];
						r_last_q  <= (rd_left == 1);
						rd_phase  <= BUSY;
					end else begin
						rd_wait <= rd_wait - 1;
					end
				end
				default: begin
					if (r_ready) begin
						r_valid_q <= 1'b0;
						r_last_q  <= 1'b0;
						rd_addr   <= rd_addr + 16'd2;
						rd_left   <= rd_left - 1;
						if (rd_left == 1) begin
							rd_phase <= IDLE;
						end else begin
							rd_wait  <= int'($urandom % 4);
							rd_phase <= GAP;
						end
					end
				end
			endcase
		end
	end

	// ##################################################
	// write channel
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_phase   <= IDLE;
			aw_ready_q <= 1'b0;
			b_valid_q  <= 1'b0;
			wr_wait    <= 0;
		end else begin
			case (wr_phase)
				IDLE: begin
					if (aw_valid) begin
						wr_wait  <= int'($urandom % 4);
						wr_phase <= ADDR;
					end
				end
				ADDR: begin
					if (wr_wait == 0) begin
						aw_ready_q <= 1'b1;
						wr_phase   <= ACCEPT;
					end else begin
						wr_wait <= wr_wait - 1;
					end
				end
				ACCEPT: begin
					aw_ready_q <= 1'b0;
					wr_wait    <= int'($urandom % 4);
					wr_phase   <= GAP;
				end
				GAP: begin
					if (wr_wait == 0) begin
						b_valid_q <= 1'b1;
						wr_phase  <= BUSY;
					end else begin
						wr_wait <= wr_wait - 1;
					end
				end
				default: begin
					if (b_ready) begin
						b_valid_q <= 1'b0;
						wr_phase  <= IDLE;
					end
				end
			endcase
		end
	end

	always @(posedge clk) begin
		if (wr_phase == ACCEPT)
			mem[aw_addr[15:1]] <= aw_data;
	end

endmodule

// instruction bank is read only, data bank takes single word bursts
module dram_model import cpu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  inst_ar_valid,
	output logic  inst_ar_ready,
	input  addr_t inst_ar_addr,
	output logic  inst_r_valid,
	output word_t inst_r_data,
	output logic  inst_r_last,
	input  logic  inst_r_ready,
	input  logic  data_ar_valid,
	output logic  data_ar_ready,
	input  addr_t data_ar_addr,
	output logic  data_r_valid,
	output word_t data_r_data,
	output logic  data_r_last,
	input  logic  data_r_ready,
	input  logic  data_aw_valid,
	output logic  data_aw_ready,
	input  addr_t data_aw_addr,
	input  word_t data_aw_data,
	output logic  data_b_valid,
	input  logic  data_b_ready
);

	dram_bank #(.BURST_LEN(ICACHE_WORDS)) inst_bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.ar_valid (inst_ar_valid),
		.ar_ready (inst_ar_ready),
		.ar_addr  (inst_ar_addr),
		.r_valid  (inst_r_valid),
		.r_data   (inst_r_data),
		.r_last   (inst_r_last),
		.r_ready  (inst_r_ready),
		.aw_valid (1'b0),
		.aw_ready (),
		.aw_addr  (16'h0000),
		.aw_data  (16'sh0000),
		.b_valid  (),
		.b_ready  (1'b0)
	);

	dram_bank #(.BURST_LEN(1)) data_bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.ar_valid (data_ar_valid),
		.ar_ready (data_ar_ready),
		.ar_addr  (data_ar_addr),
		.r_valid  (data_r_valid),
		.r_data   (data_r_data),
		.r_last   (data_r_last),
		.r_ready  (data_r_ready),
		.aw_valid (data_aw_valid),
		.aw_ready (data_aw_ready),
		.aw_addr  (data_aw_addr),
		.aw_data  (data_aw_data),
		.b_valid  (data_b_valid),
		.b_ready  (data_b_ready)
	);

endmodule

`default_nettype wire

/* bench/tb_cpu.sv */
/*
 * processor testbench: runs short programs from a table and checks
 * the stored words, stray data writes and io_stall pulse counts
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	localparam int MEM_WORDS = 32768;
	localparam int RUN_LIMIT = 20000;
	// word index of PC_RESET and of DATA_OFFSET
	localparam int PROG_BASE = 32'h800;
	localparam int DATA_BASE = 32'h800;

	typedef enum {ALU_ADD, ALU_SUB, ALU_SLT, ALU_MULT} alu_op_e;
	typedef enum {FORM_PLAIN, FORM_BEQ, FORM_JUMP} form_e;
	typedef logic signed [4:0] imm_t;

	typedef struct {
		string   name;
		alu_op_e op;
		form_e   form;
		word_t   a;
		word_t   b;
		imm_t    imm_a;
		imm_t    imm_b;
		imm_t    imm_s;
		addr_t   jump_to;
		word_t   exp;
	} row_t;

	logic  clk = 1'b0;
	logic  rst_n = 1'b0;
	logic  io_stall;
	logic  inst_ar_valid;
	logic  inst_ar_ready;
	addr_t inst_ar_addr;
	logic  inst_r_valid;
	word_t inst_r_data;
	logic  inst_r_last;
	logic  inst_r_ready;
	logic  data_ar_valid;
	logic  data_ar_ready;
	addr_t data_ar_addr;
	logic  data_r_valid;
	word_t data_r_data;
	logic  data_r_last;
	logic  data_r_ready;
	logic  data_aw_valid;
	logic  data_aw_ready;
	addr_t data_aw_addr;
	word_t data_aw_data;
	logic  data_b_valid;
	logic  data_b_ready;

	row_t  rows[$];
	word_t exp_mem [MEM_WORDS];
	int    row_errors = 0;
	int    passed = 0;
	int    failed = 0;

	always #2 clk = ~clk;

	cpu_top UUT (.*);
	dram_model dram (.*);

	// ##################################################
	// instruction encoding, fixed registers r1 op r2 into r3
	function automatic logic [15:0] enc_alu(input alu_op_e op);
		opcode_e code;
		logic    func;
		if (op == ALU_ADD || op == ALU_SUB)
			code = OP_ADD_SUB;
		else
			code = OP_SLT_MULT;
		func = (op == ALU_SUB || op == ALU_MULT);
		return {code, 4'd1, 4'd2, 4'd3, func};
	endfunction

	function automatic logic [15:0] enc_imm(input opcode_e op, input reg_idx_t rs,
		input reg_idx_t rt, input imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_jump(input addr_t target);
		return {OP_JUMP, target[12:0]};
	endfunction

	// data word index of (r0 + imm) * 2 + DATA_OFFSET
	function automatic int data_index(input imm_t imm);
		return DATA_BASE + int'(imm);
	endfunction

	function automatic word_t fill_word(input int idx);
		logic [15:0] x;
		x = 16'(idx);
		return word_t'(x ^ {x[10:0], 5'b0} ^ 16'hc3a5);
	endfunction

	function automatic void add_row(input string name, input alu_op_e op, input form_e form,
		input word_t a, input word_t b, input int ia, input int ib, input int is,
		input addr_t jump_to, input word_t exp);
		row_t r;
		r.name = name;
		r.op = op;
		r.form = form;
		r.a = a;
		r.b = b;
		r.imm_a = imm_t'(ia);
		r.imm_b = imm_t'(ib);
		r.imm_s = imm_t'(is);
		r.jump_to = jump_to;
		r.exp = exp;
		rows.push_back(r);
	endfunction

	// ##################################################
	// checks
	task automatic compare_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %0d actual %0d", what, exp, act);
			row_errors++;
		end
	endtask

	task automatic compare_count(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("MISMATCH %s expected %0d actual %0d", what, exp, act);
			row_errors++;
		end
	endtask

	task automatic load_memories(input row_t r);
		word_t w;
		int    s;
		s = data_index(r.imm_s);
		for (int i = 0; i < MEM_WORDS; i++) begin
			w = fill_word(i);
			dram.data_bank.mem[i] <= w;
			exp_mem[i] = w;
			dram.inst_bank.mem[i] <= '0;
		end
		dram.data_bank.mem[data_index(r.imm_a)] <= r.a;
		dram.data_bank.mem[data_index(r.imm_b)] <= r.b;
		exp_mem[data_index(r.imm_a)] = r.a;
		exp_mem[data_index(r.imm_b)] = r.b;
		exp_mem[s] = r.exp;
		dram.inst_bank.mem[PROG_BASE] <= enc_imm(OP_LOAD, 4'd0, 4'd1, r.imm_a);
		dram.inst_bank.mem[PROG_BASE + 1] <= enc_imm(OP_LOAD, 4'd0, 4'd2, r.imm_b);
		dram.inst_bank.mem[PROG_BASE + 2] <= enc_alu(r.op);
		case (r.form)
			FORM_PLAIN: begin
				dram.inst_bank.mem[PROG_BASE + 3] <= enc_imm(OP_STORE, 4'd0, 4'd3, r.imm_s);
			end
			// taken branch skips the marker store
			FORM_BEQ: begin
				dram.inst_bank.mem[PROG_BASE + 3] <= enc_imm(OP_BEQ, 4'd1, 4'd2, 5'sd1);
				dram.inst_bank.mem[PROG_BASE + 4] <= enc_imm(OP_STORE, 4'd0, 4'd3, r.imm_s);
				dram.inst_bank.mem[PROG_BASE + 5] <=
					enc_imm(OP_STORE, 4'd0, 4'd1, r.imm_s + 5'sd1);
				exp_mem[s + 1] = r.a;
			end
			default: begin
				dram.inst_bank.mem[PROG_BASE + 3] <= enc_jump(r.jump_to);
				dram.inst_bank.mem[PROG_BASE + 4] <=
					enc_imm(OP_STORE, 4'd0, 4'd1, r.imm_s + 5'sd1);
				dram.inst_bank.mem[int'(r.jump_to[15:1])] <=
					enc_imm(OP_STORE, 4'd0, 4'd3, r.imm_s);
			end
		endcase
	endtask

	task automatic run_row(input row_t r);
		int   exp_count;
		int   exp_writes;
		int   pulses;
		int   writes;
		int   cycles;
		int   diffs;
		logic taken;
		logic finished;
		row_errors = 0;
		taken = (r.form == FORM_BEQ) && (r.a == r.b);
		exp_count = (r.form == FORM_PLAIN) ? 4 : (r.form == FORM_BEQ && !taken) ? 6 : 5;
		exp_writes = (r.form == FORM_BEQ && !taken) ? 2 : 1;
		@(posedge clk);
		rst_n <= 1'b0;
		load_memories(r);
		for (int i = 0; i < 8; i++)
			@(posedge clk);
		rst_n <= 1'b1;
		pulses = 0;
		writes = 0;
		cycles = 0;
		finished = 1'b0;
		// the final instruction of every program is a store
		while (!finished && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (data_b_valid && data_b_ready)
				writes++;
			if (!io_stall) begin
				pulses++;
				if (writes >= exp_writes)
					finished = 1'b1;
			end
		end
		if (!finished) begin
			$display("%s: processor did not finish within %0d cycles", r.name, RUN_LIMIT);
			row_errors++;
		end else begin
			compare_count({r.name, " io_stall pulses"}, exp_count, pulses);
			compare_count({r.name, " data writes"}, exp_writes, writes);
			compare_word({r.name, " stored word"}, r.exp,
				dram.data_bank.mem[data_index(r.imm_s)]);
			diffs = 0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				if (dram.data_bank.mem[i] !== exp_mem[i])
					diffs++;
			end
			compare_count({r.name, " words changed elsewhere"}, 0, diffs);
		end
		if (row_errors == 0) begin
			$display("PASS %s", r.name);
			passed++;
		end else begin
			$display("FAIL %s with %0d errors", r.name, row_errors);
			failed++;
		end
	endtask

	// ##################################################
	// test table and run
	initial begin
		void'($urandom(32'h64ab_1c3b));
		add_row("add_pos", ALU_ADD, FORM_PLAIN, 16'sd100, 16'sd23, 2, 3, 4, '0, 16'sd123);
		add_row("add_overflow", ALU_ADD, FORM_PLAIN, 16'sh7fff, 16'sd1, 5, 6, 7, '0,
			16'sh8000);
		add_row("sub_neg", ALU_SUB, FORM_PLAIN, 16'sd5, 16'sd9, 1, 2, 8, '0, -16'sd4);
		add_row("sub_overflow", ALU_SUB, FORM_PLAIN, 16'sh8000, 16'sd1, 3, 4, 9, '0,
			16'sh7fff);
		add_row("slt_true", ALU_SLT, FORM_PLAIN, -16'sd3, 16'sd2, 10, 11, 12, '0, 16'sd1);
		add_row("slt_false", ALU_SLT, FORM_PLAIN, 16'sd7, -16'sd7, 12, 13, 14, '0, 16'sd0);
		add_row("mult_neg", ALU_MULT, FORM_PLAIN, -16'sd12, 16'sd11, 0, 1, 2, '0, -16'sd132);
		// 90000 keeps only its low half
		add_row("mult_wrap", ALU_MULT, FORM_PLAIN, 16'sd300, 16'sd300, 4, 5, 6, '0,
			16'sd24464);
		add_row("ldst_neg_imm", ALU_ADD, FORM_PLAIN, 16'sd1000, -16'sd1, -4, -3, -16, '0,
			16'sd999);
		add_row("beq_taken", ALU_ADD, FORM_BEQ, 16'sd42, 16'sd42, 1, 2, 3, '0,
			fill_word(DATA_BASE + 3));
		add_row("beq_not_taken", ALU_ADD, FORM_BEQ, 16'sd42, 16'sd43, 1, 2, 3, '0, 16'sd85);
		add_row("jump_far", ALU_ADD, FORM_JUMP, 16'sd6, 16'sd7, 7, 8, 9, 16'h1400, 16'sd13);
		// target above the high limit, clamped window
		add_row("jump_high", ALU_MULT, FORM_JUMP, 16'sd3, -16'sd5, -2, -1, -5, 16'h1f90,
			-16'sd15);
		foreach (rows[i])
			run_row(rows[i]);
		$display("tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/core_ctrl.sv */
/*
 * core sequencer: runs one instruction at a time through fetch,
 * decode, register read, execute, memory and write-back
 */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	output logic        io_stall,
	output addr_t       fetch_addr,
	input  word_t       fetch_word,
	input  logic        miss,
	output logic        refill,
	input  logic        refill_done,
	output logic        rd_en,
	output reg_idx_t    rs_idx,
	output reg_idx_t    rt_idx,
	input  word_t       rs_data,
	input  word_t       rt_data,
	output logic        wr_en,
	output reg_idx_t    wr_idx,
	output word_t       wr_data,
	mem_rd_if.requester load_rd,
	mem_wr_if.requester store_wr
);

	typedef enum logic [2:0] {
		S_REFILL,
		S_FETCH,
		S_DECODE,
		S_REG_READ,
		S_EXECUTE,
		S_MEMORY,
		S_WRITE_BACK,
		S_DONE
	} state_e;

	state_e state;
	state_e state_nxt;
	addr_t  pc;
	inst_t  inst;
	word_t  result;
	word_t  alu_out;
	word_t  imm_ext;
	addr_t  mem_addr;
	addr_t  branch_target;
	addr_t  jump_target;

	// ##################################################
	// sequencing
	always_comb begin
		state_nxt = state;
		case (state)
			S_FETCH:      state_nxt = miss ? S_REFILL : S_DECODE;
			S_REFILL:     if (refill_done) state_nxt = S_FETCH;
			S_DECODE:     state_nxt = S_REG_READ;
			S_REG_READ:   state_nxt = S_EXECUTE;
			S_EXECUTE: begin
				case (inst.r.opcode)
					OP_ADD_SUB, OP_SLT_MULT: state_nxt = S_WRITE_BACK;
					OP_LOAD, OP_STORE:       state_nxt = S_MEMORY;
					default:                 state_nxt = S_DONE;
				endcase
			end
			S_MEMORY: begin
				if (load_rd.last)
					state_nxt = S_WRITE_BACK;
				else if (store_wr.done)
					state_nxt = S_DONE;
			end
			S_WRITE_BACK: state_nxt = S_DONE;
			default:      state_nxt = S_FETCH;
		endcase
	end

	// pc points past the current instruction from decode on
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_FETCH;
			pc       <= PC_RESET;
			io_stall <= 1'b1;
		end else begin
			state    <= state_nxt;
			io_stall <= (state_nxt != S_DONE);
			if (state == S_DECODE) begin
				pc <= pc + 16'd2;
			end else if (state == S_EXECUTE) begin
				if (inst.r.opcode == OP_BEQ && rs_data == rt_data)
					pc <= branch_target;
				else if (inst.r.opcode == OP_JUMP)
					pc <= jump_target;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_DECODE)
			inst <= fetch_word;
		if (state == S_EXECUTE)
			result <= alu_out;
		else if (state == S_MEMORY && load_rd.last)
			result <= load_rd.data;
	end

	// ##################################################
	// execute
	assign imm_ext = {{11{inst.i.imm[4]}}, inst.i.imm};
	assign branch_target = pc + addr_t'(imm_ext <<< 1);
	assign jump_target = {3'b000, inst.j.target};
	// word address scaled to bytes, then into the data region
	assign mem_addr = addr_t'((rs_data + imm_ext) <<< 1) + DATA_OFFSET;

	always_comb begin
		case (inst.r.opcode)
			OP_ADD_SUB:
				alu_out = inst.r.func ? rs_data - rt_data : rs_data + rt_data;
			OP_SLT_MULT: begin
				if (inst.r.func)
					alu_out = word_t'(rs_data * rt_data);
				else
					alu_out = (rs_data < rt_data) ? word_t'(1) : word_t'(0);
			end
			default:
				alu_out = '0;
		endcase
	end

	// cache side
	assign fetch_addr = pc;
	assign refill = (state == S_FETCH) && miss;

	// register file side
	assign rd_en = (state == S_REG_READ);
	assign rs_idx = inst.r.rs;
	assign rt_idx = inst.r.rt;
	assign wr_en = (state == S_WRITE_BACK);
	// loads write rt, ALU ops write rd
	assign wr_idx = (inst.r.opcode == OP_LOAD) ? inst.r.rt : inst.r.rd;
	assign wr_data = result;

	// data memory requests go out in the execute cycle
	assign load_rd.req = (state == S_EXECUTE) && (inst.r.opcode == OP_LOAD);
	assign load_rd.addr = mem_addr;
	assign store_wr.req = (state == S_EXECUTE) && (inst.r.opcode == OP_STORE);
	assign store_wr.addr = mem_addr;
	assign store_wr.data = rt_data;

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
/*
 * cpu package: word, address and instruction types, opcodes,
 * reset and data address constants, and the instruction window rules
 */
`default_nettype none

package cpu_pkg;

	typedef logic signed [15:0] word_t;
	typedef logic [15:0] addr_t;
	typedef logic [3:0] reg_idx_t;

	typedef enum logic [2:0] {
		OP_ADD_SUB  = 3'd0,
		OP_SLT_MULT = 3'd1,
		OP_LOAD     = 3'd2,
		OP_STORE    = 3'd3,
		OP_BEQ      = 3'd4,
		OP_JUMP     = 3'd5
	} opcode_e;

	// ##################################################
	// instruction formats, all views of the same 16 bits
	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		reg_idx_t    rd;
		logic        func;
	} r_form_t;

	typedef struct packed {
		opcode_e            opcode;
		reg_idx_t           rs;
		reg_idx_t           rt;
		logic signed [4:0]  imm;
	} i_form_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [12:0] target;
	} j_form_t;

	typedef union packed {
		r_form_t r;
		i_form_t i;
		j_form_t j;
	} inst_t;

	// ##################################################
	// address map
	localparam addr_t PC_RESET    = 16'h1000;
	localparam addr_t DATA_OFFSET = 16'h1000;

	// window of 128 words around the pc
	localparam int    ICACHE_WORDS   = 128;
	localparam addr_t WIN_BACK       = 16'd124;
	localparam addr_t WIN_FWD        = 16'd130;
	localparam addr_t WIN_LOW_LIMIT  = 16'h107c;
	localparam addr_t WIN_LOW_BASE   = 16'h1000;
	localparam addr_t WIN_HIGH_LIMIT = 16'h1f7c;
	localparam addr_t WIN_HIGH_BASE  = 16'h1f00;

	// lower bound of a refilled window, clamped at both program ends
	function automatic addr_t window_base(input addr_t pc);
		addr_t base;
		if (pc < WIN_LOW_LIMIT)
			base = WIN_LOW_BASE;
		else if (pc > WIN_HIGH_LIMIT)
			base = WIN_HIGH_BASE;
		else
			base = pc - WIN_BACK;
		return base;
	endfunction

endpackage

`default_nettype wire

/* logic/cpu_top.sv */
/*
 * processor top: core, register file, instruction window
 * and the instruction read, data read and data write ports
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	output logic  io_stall,
	// instruction DRAM read
	output logic  inst_ar_valid,
	input  logic  inst_ar_ready,
	output addr_t inst_ar_addr,
	input  logic  inst_r_valid,
	input  word_t inst_r_data,
	input  logic  inst_r_last,
	output logic  inst_r_ready,
	// data DRAM read
	output logic  data_ar_valid,
	input  logic  data_ar_ready,
	output addr_t data_ar_addr,
	input  logic  data_r_valid,
	input  word_t data_r_data,
	input  logic  data_r_last,
	output logic  data_r_ready,
	// data DRAM write
	output logic  data_aw_valid,
	input  logic  data_aw_ready,
	output addr_t data_aw_addr,
	output word_t data_aw_data,
	input  logic  data_b_valid,
	output logic  data_b_ready
);

	addr_t    fetch_addr;
	word_t    fetch_word;
	logic     miss;
	logic     refill;
	logic     refill_done;
	logic     rd_en;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t    rs_data;
	word_t    rt_data;
	logic     wr_en;
	reg_idx_t wr_idx;
	word_t    wr_data;

	mem_rd_if inst_rd_bus ();
	mem_rd_if data_rd_bus ();
	mem_wr_if data_wr_bus ();

	core_ctrl u_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.io_stall    (io_stall),
		.fetch_addr  (fetch_addr),
		.fetch_word  (fetch_word),
		.miss        (miss),
		.refill      (refill),
		.refill_done (refill_done),
		.rd_en       (rd_en),
		.rs_idx      (rs_idx),
		.rt_idx      (rt_idx),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.wr_en       (wr_en),
		.wr_idx      (wr_idx),
		.wr_data     (wr_data),
		.load_rd     (data_rd_bus),
		.store_wr    (data_wr_bus)
	);

	reg_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_en   (rd_en),
		.rs_idx  (rs_idx),
		.rt_idx  (rt_idx),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data)
	);

	inst_cache u_icache (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_addr  (fetch_addr),
		.fetch_word  (fetch_word),
		.miss        (miss),
		.refill      (refill),
		.refill_done (refill_done),
		.fill        (inst_rd_bus)
	);

	// instruction side reads a whole window per request
	dram_read_port #(.BURST_LEN(ICACHE_WORDS)) u_inst_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_side (inst_rd_bus),
		.ar_valid (inst_ar_valid),
		.ar_ready (inst_ar_ready),
		.ar_addr  (inst_ar_addr),
		.r_valid  (inst_r_valid),
		.r_data   (inst_r_data),
		.r_last   (inst_r_last),
		.r_ready  (inst_r_ready)
	);

	dram_read_port #(.BURST_LEN(1)) u_data_rd_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_side (data_rd_bus),
		.ar_valid (data_ar_valid),
		.ar_ready (data_ar_ready),
		.ar_addr  (data_ar_addr),
		.r_valid  (data_r_valid),
		.r_data   (data_r_data),
		.r_last   (data_r_last),
		.r_ready  (data_r_ready)
	);

	dram_write_port u_data_wr_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_side (data_wr_bus),
		.aw_valid (data_aw_valid),
		.aw_ready (data_aw_ready),
		.aw_addr  (data_aw_addr),
		.aw_data  (data_aw_data),
		.b_valid  (data_b_valid),
		.b_ready  (data_b_ready)
	);

endmodule

`default_nettype wire

/* logic/dram_read_port.sv */
/*
 * DRAM read master: one address handshake, then a burst of BURST_LEN beats
 */
`timescale 1ns/1ps
`default_nettype none

module dram_read_port import cpu_pkg::*; #(
	parameter int BURST_LEN = 1
) (
	input  logic   clk,
	input  logic   rst_n,
	mem_rd_if.port req_side,
	output logic   ar_valid,
	input  logic   ar_ready,
	output addr_t  ar_addr,
	input  logic   r_valid,
	input  word_t  r_data,
	input  logic   r_last,
	output logic   r_ready
);

	typedef logic [$clog2(BURST_LEN + 1)-1:0] cnt_t;

	cnt_t beat_cnt;
	logic beat;
	logic final_beat;

	assign beat = r_valid && r_ready;
	// a counted end covers DRAMs that leave r_last low on single beats
	assign final_beat = r_last || (beat_cnt == cnt_t'(BURST_LEN - 1));

	assign req_side.data = r_data;
	assign req_side.valid = beat;
	assign req_side.last = beat && final_beat;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_valid <= 1'b0;
			r_ready  <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (req_side.req) begin
				ar_valid <= 1'b1;
				beat_cnt <= '0;
			end else if (ar_valid && ar_ready) begin
				ar_valid <= 1'b0;
				r_ready  <= 1'b1;
			end
			if (req_side.last) begin
				r_ready  <= 1'b0;
				beat_cnt <= '0;
			end else if (beat) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_side.req)
			ar_addr <= req_side.addr;
	end

endmodule

`default_nettype wire

/* logic/dram_write_port.sv */
/*
 * DRAM write master: address and data in one handshake, then the response
 */
`timescale 1ns/1ps
`default_nettype none

module dram_write_port import cpu_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	mem_wr_if.port req_side,
	output logic   aw_valid,
	input  logic   aw_ready,
	output addr_t  aw_addr,
	output word_t  aw_data,
	input  logic   b_valid,
	output logic   b_ready
);

	// one cycle pulse, b_ready drops right after
	assign req_side.done = b_valid && b_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_valid <= 1'b0;
			b_ready  <= 1'b0;
		end else begin
			if (req_side.req) begin
				aw_valid <= 1'b1;
			end else if (aw_valid && aw_ready) begin
				aw_valid <= 1'b0;
				b_ready  <= 1'b1;
			end
			if (req_side.done)
				b_ready <= 1'b0;
		end
	end

	// address and word held for the whole handshake
	always_ff @(posedge clk) begin
		if (req_side.req) begin
			aw_addr <= req_side.addr;
			aw_data <= req_side.data;
		end
	end

endmodule

`default_nettype wire

/* logic/inst_cache.sv */
/*
 * instruction window: 128 words around the pc, refilled
 * by one burst whenever the fetch address falls outside it
 */
`timescale 1ns/1ps
`default_nettype none

module inst_cache import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  addr_t       fetch_addr,
	output word_t       fetch_word,
	output logic        miss,
	input  logic        refill,
	output logic        refill_done,
	mem_rd_if.requester fill
);

	word_t mem [ICACHE_WORDS];
	addr_t win_lo;
	addr_t win_hi;
	logic  win_ok;
	addr_t offset;
	logic [$clog2(ICACHE_WORDS)-1:0] fill_idx;

	// burst starts at the new lower bound
	assign fill.req = refill;
	assign fill.addr = window_base(fetch_addr);
	assign refill_done = fill.last;

	assign miss = !win_ok || (fetch_addr < win_lo) || (fetch_addr > win_hi);
	assign offset = fetch_addr - win_lo;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_ok   <= 1'b0;
			fill_idx <= '0;
		end else if (refill) begin
			win_ok   <= 1'b0;
			fill_idx <= '0;
		end else if (fill.valid) begin
			fill_idx <= fill_idx + 1'b1;
			if (fill.last)
				win_ok <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (refill) begin
			win_lo <= window_base(fetch_addr);
			win_hi <= window_base(fetch_addr) + WIN_BACK + WIN_FWD;
		end
		if (fill.valid)
			mem[fill_idx] <= fill.data;
		// byte offset to word index
		fetch_word <= mem[offset[$clog2(ICACHE_WORDS):1]];
	end

endmodule

`default_nettype wire

/* logic/mem_if.sv */
/*
 * memory request links between the core-side blocks and the DRAM ports
 */
`timescale 1ns/1ps
`default_nettype none

// burst read: one req pulse, then beats until last
interface mem_rd_if import cpu_pkg::*; ();
	logic  req;
	addr_t addr;
	word_t data;
	logic  valid;
	logic  last;

	modport requester (output req, addr, input data, valid, last);
	modport port (input req, addr, output data, valid, last);
endinterface

// single word write, done pulses on the write response
interface mem_wr_if import cpu_pkg::*; ();
	logic  req;
	addr_t addr;
	word_t data;
	logic  done;

	modport requester (output req, addr, data, input done);
	modport port (input req, addr, data, output done);
endinterface

`default_nettype wire

/* logic/reg_file.sv */
/*
 * register file: sixteen signed words, two registered read ports
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rd_en,
	input  reg_idx_t rs_idx,
	input  reg_idx_t rt_idx,
	output word_t    rs_data,
	output word_t    rt_data,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data
);

	word_t regs [16];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// operands show up the cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rs_data <= regs[rs_idx];
			rt_data <= regs[rt_idx];
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the processor testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_cpu -f sim.f -o tb_cpu
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
	exit 0
fi
exit 1

/* sim.f */
logic/cpu_pkg.sv
logic/mem_if.sv
logic/core_ctrl.sv
logic/reg_file.sv
logic/inst_cache.sv
logic/dram_read_port.sv
logic/dram_write_port.sv
logic/cpu_top.sv
bench/dram_model.sv
bench/tb_cpu.sv
